/* bench/cfr_clip_checker.sv */
// Concurrent assertions on the CFR top level
// Reset clearing, bypass latency, enable gating of the excess
`timescale 1ns/1ps
`default_nettype none

module cfr_clip_checker #(
  parameter int DATA_WIDTH = cfr_pkg::DATA_WIDTH_DEF,
  parameter int ITERATIONS = cfr_pkg::ITERATIONS_DEF
) (
  input logic                         clk,
  input logic                         rst_n,
  input logic signed [DATA_WIDTH-1:0] data_i,
  input logic                         enable,
  input logic                         enable_s,
  input logic        [DATA_WIDTH:0]   excess,
  input logic signed [DATA_WIDTH-1:0] clip_i,
  input logic signed [DATA_WIDTH-1:0] clip_q
);

  // Input to output delay in clock cycles
  localparam int LATENCY = 2 * ITERATIONS + 7;

  // Consecutive edges out of reset with clipping off, saturating
  int bypass_run;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bypass_run <= 0;
    end else if (enable) begin
      bypass_run <= 0;
    end else if (bypass_run < LATENCY) begin
      bypass_run <= bypass_run + 1;
    end
  end

  // Synchronous reset clears the output register on the next edge
  reset_clears_outputs: assert property (@(posedge clk)
    !rst_n |=> (clip_i == 0 && clip_q == 0))
    else $error("outputs not cleared by reset");

  // Whole pipeline run in bypass, so the output is the delayed input
  bypass_passes_input: assert property (@(posedge clk)
    (bypass_run >= LATENCY) |-> (clip_i == $past(data_i, LATENCY)))
    else $error("bypass output differs from delayed input");

  // No overshoot may leave the excess stage while clipping is off
  excess_gated_by_enable: assert property (@(posedge clk) disable iff (!rst_n)
    !enable_s |=> (excess == 0))
    else $error("excess nonzero with synchronized enable low");

endmodule

bind cfr_clip_top cfr_clip_checker #(
  .DATA_WIDTH(DATA_WIDTH),
  .ITERATIONS(ITERATIONS)
) u_chk (
  .clk     (clk),
  .rst_n   (rst_n),
  .data_i  (data_i),
  .enable  (enable),
  .enable_s(u_excess.enable_s),
  .excess  (excess),
  .clip_i  (clip_i),
  .clip_q  (clip_q)
);

`default_nettype wire

/* bench/cfr_clip_tb.sv */
// Testbench for the hard-clipping CFR top level
// Clock, reset, stimulus, reference model and output comparison
`timescale 1ns/1ps
`default_nettype none

module cfr_clip_tb;

  localparam int DATA_WIDTH  = cfr_pkg::DATA_WIDTH_DEF;
  localparam int ITERATIONS  = cfr_pkg::ITERATIONS_DEF;
  localparam int PHASE_WIDTH = cfr_pkg::PHASE_WIDTH_DEF;
  // Input to output delay in clock cycles
  localparam int LATENCY = 2 * ITERATIONS + 7;
  // Allowed error per component on clipped samples
  localparam int TOL = 4;
  // Below threshold minus this the CORDIC magnitude cannot trip the clipper
  localparam int MARGIN = 8;

  logic                         clk;
  logic                         rst_n;
  logic signed [DATA_WIDTH-1:0] data_i;
  logic signed [DATA_WIDTH-1:0] data_q;
  logic                         enable;
  logic        [DATA_WIDTH:0]   threshold;
  logic signed [DATA_WIDTH-1:0] clip_i;
  logic signed [DATA_WIDTH-1:0] clip_q;

  int cycle = 0;
  int err_count = 0;
  int chk_count = 0;
  int test_err_start;
  int test_chk_start;
  // Samples in flight, one entry per driven cycle
  int pend_due[$];
  int pend_i[$];
  int pend_q[$];
  int pend_en[$];
  int pend_thr[$];

  cfr_clip_top #(
    .DATA_WIDTH (DATA_WIDTH),
    .ITERATIONS (ITERATIONS),
    .PHASE_WIDTH(PHASE_WIDTH)
  ) dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .data_i   (data_i),
    .data_q   (data_q),
    .enable   (enable),
    .threshold(threshold),
    .clip_i   (clip_i),
    .clip_q   (clip_q)
  );

  always #10 clk = ~clk;

  // Cycle count, stable at every falling edge
  always @(posedge clk) cycle <= cycle + 1;

  function automatic int round_real(input real x);
    return $rtoi($floor(x + 0.5));
  endfunction

  function automatic int abs_int(input int v);
    return (v < 0) ? -v : v;
  endfunction

  // Hard clip to the threshold circle, phase kept
  function automatic void clip_reference(input int si, input int sq, input int en,
                                         input int thr, output int ri, output int rq);
    real m;
    m = $sqrt(real'(si) * si + real'(sq) * sq);
    ri = si;
    rq = sq;
    if (en != 0 && m > real'(thr)) begin
      ri = round_real(si * real'(thr) / m);
      rq = round_real(sq * real'(thr) / m);
    end
  endfunction

  //********************************************************************
  // Comparison, each output checked LATENCY cycles after its input
  //********************************************************************
  always @(negedge clk) begin
    int si;
    int sq;
    int en;
    int thr;
    int ei;
    int eq;
    real m_in;
    real m_out;
    if (pend_due.size() > 0 && pend_due[0] <= cycle) begin
      void'(pend_due.pop_front());
      si  = pend_i.pop_front();
      sq  = pend_q.pop_front();
      en  = pend_en.pop_front();
      thr = pend_thr.pop_front();
      chk_count++;
      clip_reference(si, sq, en, thr, ei, eq);
      m_in = $sqrt(real'(si) * si + real'(sq) * sq);
      if (en == 0 || m_in < real'(thr - MARGIN)) begin
        assert (clip_i == ei && clip_q == eq) else begin
          err_count++;
          $display("error: %0t ns: got (%0d, %0d), expected (%0d, %0d), input (%0d, %0d)",
                   $time, clip_i, clip_q, ei, eq, si, sq);
        end
      end else begin
        assert (abs_int(clip_i - ei) <= TOL && abs_int(clip_q - eq) <= TOL) else begin
          err_count++;
          $display("error: %0t ns: got (%0d, %0d), expected (%0d, %0d) +-%0d, input (%0d, %0d)",
                   $time, clip_i, clip_q, ei, eq, TOL, si, sq);
        end
        if (m_in > real'(thr)) begin
          m_out = $sqrt(real'(clip_i) * clip_i + real'(clip_q) * clip_q);
          assert (m_out <= real'(thr + TOL)) else begin
            err_count++;
            $display("error: %0t ns: clipped magnitude %f above threshold %0d",
                     $time, m_out, thr);
          end
          // Sign only checked where the component is clear of the tolerance
          assert ((ei <= TOL || clip_i > 0) && (ei >= -TOL || clip_i < 0) &&
                  (eq <= TOL || clip_q > 0) && (eq >= -TOL || clip_q < 0)) else begin
            err_count++;
            $display("error: %0t ns: sign flipped, got (%0d, %0d), expected (%0d, %0d)",
                     $time, clip_i, clip_q, ei, eq);
          end
        end
      end
    end
  end

  //********************************************************************
  // Stimulus helpers
  //********************************************************************
  // One sample on the falling edge, queued for comparison
  task automatic drive_sample(input int si, input int sq);
    @(negedge clk);
    data_i = si[DATA_WIDTH-1:0];
    data_q = sq[DATA_WIDTH-1:0];
    pend_due.push_back(cycle + LATENCY);
    pend_i.push_back(si);
    pend_q.push_back(sq);
    pend_en.push_back(int'(enable));
    pend_thr.push_back(int'(threshold));
  endtask

  // Random phase, magnitude in [lo, hi)
  task automatic drive_polar(input int lo, input int hi);
    real ang;
    real m;
    ang = 6.283185307 * real'($urandom % 65536) / 65536.0;
    m = real'(lo) + real'($urandom % (hi - lo));
    drive_sample(round_real(m * $cos(ang)), round_real(m * $sin(ang)));
  endtask

  task automatic set_controls(input logic en, input int thr);
    @(negedge clk);
    data_i    = '0;
    data_q    = '0;
    enable    = en;
    threshold = thr[DATA_WIDTH:0];
  endtask

  // Hold zero input until every queued sample is compared
  task automatic drain_pipeline();
    int waited;
    waited = 0;
    while (pend_due.size() > 0 && waited < LATENCY + 10) begin
      @(negedge clk);
      data_i = '0;
      data_q = '0;
      waited++;
    end
    if (pend_due.size() > 0) begin
      $display("timeout: pipeline still holds %0d samples after %0d cycles",
               pend_due.size(), waited);
      $display("ERRORS FOUND");
      $finish;
    end
  endtask

  task automatic start_test();
    test_err_start = err_count;
    test_chk_start = chk_count;
  endtask

  task automatic report_test(input int num, input string name);
    $display("test %0d %s: %0d checks, %0d errors", num, name,
             chk_count - test_chk_start, err_count - test_err_start);
  endtask

  //********************************************************************
  // Test sequence
  //********************************************************************
  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    data_i    = '0;
    data_q    = '0;
    enable    = 1'b0;
    threshold = 16000;
    void'($urandom(64));
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Outputs stay zero until the first sample has crossed the pipeline
    start_test();
    for (int k = 0; k < LATENCY; k++) begin
      drive_sample(int'($urandom % 65536) - 32768, int'($urandom % 65536) - 32768);
      chk_count++;
      assert (clip_i == 0 && clip_q == 0) else begin
        err_count++;
        $display("error: %0t ns: output (%0d, %0d) not zero after reset",
                 $time, clip_i, clip_q);
      end
    end
    drain_pipeline();
    report_test(1, "reset");

    // Lone impulse among zeros, any other delay shows as a mismatch
    start_test();
    set_controls(1'b1, 16000);
    repeat (4) drive_sample(0, 0);
    drive_sample(1234, -567);
    repeat (LATENCY + 2) drive_sample(0, 0);
    drain_pipeline();
    report_test(2, "latency");

    start_test();
    set_controls(1'b0, 4000);
    repeat (4) drive_sample(0, 0);
    repeat (200) drive_sample(int'($urandom % 65536) - 32768, int'($urandom % 65536) - 32768);
    drain_pipeline();
    report_test(3, "bypass");

    start_test();
    set_controls(1'b1, 16000);
    repeat (4) drive_sample(0, 0);
    repeat (200) drive_polar(0, 16000 - 100);
    drain_pipeline();
    report_test(4, "below threshold");

    // Overshoot kept moderate so CORDIC phase error stays inside TOL
    start_test();
    repeat (200) drive_polar(16000 + 16, 16000 + 1000);
    drain_pipeline();
    report_test(5, "clipping");

    start_test();
    set_controls(1'b1, 9000);
    repeat (LATENCY + 3) drive_sample(0, 0);
    repeat (200) drive_polar(9000 - 2000, 9000 + 1000);
    drain_pipeline();
    report_test(6, "threshold change");

    $display("total: %0d checks, %0d errors", chk_count, err_count);
    if (err_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* cfr_clip_top.f */
hdl/cfr_pkg.sv
hdl/cordic_vectoring.sv
hdl/clip_excess.sv
hdl/cordic_rotation.sv
hdl/clip_subtract.sv
hdl/cfr_clip_top.sv
bench/cfr_clip_checker.sv
bench/cfr_clip_tb.sv

/* hdl/cfr_clip_top.sv */
// Hard-clipping CFR top level
// Vectoring CORDIC, excess stage, rotation CORDIC, delayed subtract
`timescale 1ns/1ps
`default_nettype none

module cfr_clip_top #(
  parameter int DATA_WIDTH  = cfr_pkg::DATA_WIDTH_DEF,
  parameter int ITERATIONS  = cfr_pkg::ITERATIONS_DEF,
  parameter int PHASE_WIDTH = cfr_pkg::PHASE_WIDTH_DEF
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic signed [DATA_WIDTH-1:0] data_i,
  input  logic signed [DATA_WIDTH-1:0] data_q,
  // Level controls, 1 = clip, 0 = bypass
  input  logic                         enable,
  input  logic        [DATA_WIDTH:0]   threshold,
  output logic signed [DATA_WIDTH-1:0] clip_i,
  output logic signed [DATA_WIDTH-1:0] clip_q
);

  // Vectoring L+2, excess 2, rotation L+2
  localparam int DELAY = 2 * ITERATIONS + 6;

  logic        [DATA_WIDTH:0]    mag;
  logic        [PHASE_WIDTH-1:0] phase;
  logic        [DATA_WIDTH:0]    excess;
  logic        [PHASE_WIDTH-1:0] phase_d;
  logic signed [DATA_WIDTH+1:0]  corr_i;
  logic signed [DATA_WIDTH+1:0]  corr_q;

  //********************************************************************
  // Polar conversion and overshoot
  //********************************************************************
  cordic_vectoring #(
    .DATA_WIDTH (DATA_WIDTH),
    .ITERATIONS (ITERATIONS),
    .PHASE_WIDTH(PHASE_WIDTH)
  ) u_vec (
    .clk   (clk),
    .rst_n (rst_n),
    .data_i(data_i),
    .data_q(data_q),
    .mag   (mag),
    .phase (phase)
  );

  clip_excess #(
    .DATA_WIDTH (DATA_WIDTH),
    .PHASE_WIDTH(PHASE_WIDTH)
  ) u_excess (
    .clk      (clk),
    .rst_n    (rst_n),
    .enable   (enable),
    .threshold(threshold),
    .mag      (mag),
    .phase    (phase),
    .excess   (excess),
    .phase_d  (phase_d)
  );

  //********************************************************************
  // Correction vector and subtraction
  //********************************************************************
  cordic_rotation #(
    .DATA_WIDTH (DATA_WIDTH),
    .ITERATIONS (ITERATIONS),
    .PHASE_WIDTH(PHASE_WIDTH)
  ) u_rot (
    .clk    (clk),
    .rst_n  (rst_n),
    .excess (excess),
    .phase_d(phase_d),
    .corr_i (corr_i),
    .corr_q (corr_q)
  );

  clip_subtract #(
    .DATA_WIDTH(DATA_WIDTH),
    .DELAY     (DELAY)
  ) u_sub (
    .clk   (clk),
    .rst_n (rst_n),
    .data_i(data_i),
    .data_q(data_q),
    .corr_i(corr_i),
    .corr_q(corr_q),
    .clip_i(clip_i),
    .clip_q(clip_q)
  );

endmodule

`default_nettype wire

/* hdl/cfr_pkg.sv */
// Default datapath widths and CORDIC iteration count
// Arctangent table and inverse gain shared by both CORDIC engines
`default_nettype none

package cfr_pkg;

  // Signed I/Q sample width
  localparam int DATA_WIDTH_DEF = 16;

  // Number of CORDIC micro-rotations per engine, at most 24
  localparam int ITERATIONS_DEF = 12;

  // Phase word, full scale is one turn, below 32 bits
  localparam int PHASE_WIDTH_DEF = 16;

  // atan(2^-i) as a fraction of one turn, 32-bit resolution
  // Engines round this down to their own phase width
  localparam logic [31:0] cordic_atan [24] = '{
    32'h20000000, 32'h12E4051E, 32'h09FB385B, 32'h051111D4,
    32'h028B0D43, 32'h0145D7E1, 32'h00A2F61E, 32'h00517C55,
    32'h0028BE53, 32'h00145F2F, 32'h000A2F98, 32'h000517CC,
    32'h00028BE6, 32'h000145F3, 32'h0000A2FA, 32'h0000517D,
    32'h000028BE, 32'h0000145F, 32'h00000A30, 32'h00000518,
    32'h0000028C, 32'h00000146, 32'h000000A3, 32'h00000051
  };

  // 1/K of about 0.60725, unsigned Q1.15
  localparam logic [15:0] CORDIC_GAIN_COMP = 16'h4DBB;

endpackage

`default_nettype wire

/* hdl/clip_excess.sv */
// Control synchronizer for enable and threshold
// Two-stage magnitude minus threshold, gated by enable
`timescale 1ns/1ps
`default_nettype none

module clip_excess #(
  parameter int DATA_WIDTH  = cfr_pkg::DATA_WIDTH_DEF,
  parameter int PHASE_WIDTH = cfr_pkg::PHASE_WIDTH_DEF
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   enable,
  input  logic [DATA_WIDTH:0]    threshold,
  input  logic [DATA_WIDTH:0]    mag,
  input  logic [PHASE_WIDTH-1:0] phase,
  output logic [DATA_WIDTH:0]    excess,
  output logic [PHASE_WIDTH-1:0] phase_d
);

  logic                         enable_meta;
  logic                         enable_s;
  logic        [DATA_WIDTH:0]   thresh_meta;
  logic        [DATA_WIDTH:0]   thresh_s;
  logic signed [DATA_WIDTH+1:0] diff_r;
  logic        [PHASE_WIDTH-1:0] phase_r;

  // Quasi-static controls, two flops each
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      enable_meta <= 1'b0;
      enable_s    <= 1'b0;
      thresh_meta <= '0;
      thresh_s    <= '0;
    end else begin
      enable_meta <= enable;
      enable_s    <= enable_meta;
      thresh_meta <= threshold;
      thresh_s    <= thresh_meta;
    end
  end

  // Stage 1: signed overshoot, phase rides along
  // Stage 2: keep only positive overshoot when clipping is on
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      diff_r  <= '0;
      phase_r <= '0;
      excess  <= '0;
      phase_d <= '0;
    end else begin
      diff_r  <= $signed({1'b0, mag}) - $signed({1'b0, thresh_s});
      phase_r <= phase;
      if (enable_s && (diff_r > 0)) begin
        excess <= diff_r[DATA_WIDTH:0];
      end else begin
        excess <= '0;
      end
      phase_d <= phase_r;
    end
  end

endmodule

`default_nettype wire

/* hdl/clip_subtract.sv */
// Input delay line matched to the correction path
// Saturating subtraction of the I/Q correction
`timescale 1ns/1ps
`default_nettype none

module clip_subtract #(
  parameter int DATA_WIDTH = cfr_pkg::DATA_WIDTH_DEF,
  parameter int DELAY      = 2 * cfr_pkg::ITERATIONS_DEF + 6
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic signed [DATA_WIDTH-1:0] data_i,
  input  logic signed [DATA_WIDTH-1:0] data_q,
  input  logic signed [DATA_WIDTH+1:0] corr_i,
  input  logic signed [DATA_WIDTH+1:0] corr_q,
  output logic signed [DATA_WIDTH-1:0] clip_i,
  output logic signed [DATA_WIDTH-1:0] clip_q
);

  localparam logic signed [DATA_WIDTH+2:0] SAT_MAX = (DATA_WIDTH + 3)'(2**(DATA_WIDTH-1) - 1);
  localparam logic signed [DATA_WIDTH+2:0] SAT_MIN = -(DATA_WIDTH + 3)'(2**(DATA_WIDTH-1));

  logic signed [DATA_WIDTH-1:0] d_i [0:DELAY-1];
  logic signed [DATA_WIDTH-1:0] d_q [0:DELAY-1];
  logic signed [DATA_WIDTH+2:0] diff_i;
  logic signed [DATA_WIDTH+2:0] diff_q;

  // Clamp to the output sample range
  function automatic logic signed [DATA_WIDTH-1:0] sat(input logic signed [DATA_WIDTH+2:0] v);
    if (v > SAT_MAX) begin
      return SAT_MAX[DATA_WIDTH-1:0];
    end else if (v < SAT_MIN) begin
      return SAT_MIN[DATA_WIDTH-1:0];
    end
    return v[DATA_WIDTH-1:0];
  endfunction

  // Full-width difference, no wrap before saturation
  assign diff_i = (DATA_WIDTH + 3)'(d_i[DELAY-1]) - (DATA_WIDTH + 3)'(corr_i);
  assign diff_q = (DATA_WIDTH + 3)'(d_q[DELAY-1]) - (DATA_WIDTH + 3)'(corr_q);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int k = 0; k < DELAY; k++) begin
        d_i[k] <= '0;
        d_q[k] <= '0;
      end
      clip_i <= '0;
      clip_q <= '0;
    end else begin
      d_i[0] <= data_i;
      d_q[0] <= data_q;
      for (int k = 1; k < DELAY; k++) begin
        d_i[k] <= d_i[k-1];
        d_q[k] <= d_q[k-1];
      end
      clip_i <= sat(diff_i);
      clip_q <= sat(diff_q);
    end
  end

endmodule

`default_nettype wire

/* hdl/cordic_rotation.sv */
// Pipelined rotation CORDIC, excess magnitude and phase in
// Prescale by 1/K, ITERATIONS micro-rotations, quadrant sign flip
`timescale 1ns/1ps
`default_nettype none

module cordic_rotation #(
  parameter int DATA_WIDTH  = cfr_pkg::DATA_WIDTH_DEF,
  parameter int ITERATIONS  = cfr_pkg::ITERATIONS_DEF,
  parameter int PHASE_WIDTH = cfr_pkg::PHASE_WIDTH_DEF
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic        [DATA_WIDTH:0]   excess,
  input  logic        [PHASE_WIDTH-1:0] phase_d,
  output logic signed [DATA_WIDTH+1:0] corr_i,
  output logic signed [DATA_WIDTH+1:0] corr_q
);

  localparam int GUARD = 4;
  // Excess is DATA_WIDTH+1 bits unsigned, plus sign and one spare bit
  localparam int XW = DATA_WIDTH + 3 + GUARD;
  localparam int PRE_SHIFT = 15 - GUARD;
  localparam logic [DATA_WIDTH+16:0] PRE_HALF = (DATA_WIDTH + 17)'(1) << (PRE_SHIFT - 1);
  localparam logic signed [XW-1:0] POST_HALF = XW'(1) <<< (GUARD - 1);

  logic signed [XW-1:0]          x_r [0:ITERATIONS];
  logic signed [XW-1:0]          y_r [0:ITERATIONS];
  // Last residual angle is not needed
  logic signed [PHASE_WIDTH-1:0] z_r [0:ITERATIONS-1];
  logic                          flip_r [0:ITERATIONS];
  logic                          fold;
  logic        [DATA_WIDTH+16:0] pre_prod;
  logic signed [XW-1:0]          x_round;
  logic signed [XW-1:0]          y_round;
  logic signed [DATA_WIDTH+1:0]  x_corr;
  logic signed [DATA_WIDTH+1:0]  y_corr;

  function automatic logic signed [PHASE_WIDTH-1:0] atan_step(input int i);
    logic [31:0] rounded;
    rounded = cfr_pkg::cordic_atan[i] + (32'd1 << (31 - PHASE_WIDTH));
    return rounded[31 -: PHASE_WIDTH];
  endfunction

  // Phase outside +-90 degrees, top two bits differ
  assign fold = phase_d[PHASE_WIDTH-1] ^ phase_d[PHASE_WIDTH-2];
  // Excess times 1/K, keeping GUARD fraction bits
  assign pre_prod = excess * cfr_pkg::CORDIC_GAIN_COMP + PRE_HALF;

  assign x_round = (x_r[ITERATIONS] + POST_HALF) >>> GUARD;
  assign y_round = (y_r[ITERATIONS] + POST_HALF) >>> GUARD;
  assign x_corr  = x_round[DATA_WIDTH+1:0];
  assign y_corr  = y_round[DATA_WIDTH+1:0];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i <= ITERATIONS; i++) begin
        x_r[i]    <= '0;
        y_r[i]    <= '0;
        flip_r[i] <= 1'b0;
      end
      for (int i = 0; i < ITERATIONS; i++) begin
        z_r[i] <= '0;
      end
      corr_i <= '0;
      corr_q <= '0;
    end else begin
      // Start on the x axis, half a turn removed by inverting the MSB
      x_r[0]    <= XW'(pre_prod >> PRE_SHIFT);
      y_r[0]    <= '0;
      flip_r[0] <= fold;
      z_r[0]    <= fold ? {~phase_d[PHASE_WIDTH-1], phase_d[PHASE_WIDTH-2:0]} : phase_d;
      //****************************************************************
      // Micro-rotations, drive the residual angle to zero
      //****************************************************************
      for (int i = 0; i < ITERATIONS; i++) begin
        if (z_r[i] < 0) begin
          x_r[i+1] <= x_r[i] + (y_r[i] >>> i);
          y_r[i+1] <= y_r[i] - (x_r[i] >>> i);
        end else begin
          x_r[i+1] <= x_r[i] - (y_r[i] >>> i);
          y_r[i+1] <= y_r[i] + (x_r[i] >>> i);
        end
        flip_r[i+1] <= flip_r[i];
      end
      for (int i = 0; i < ITERATIONS - 1; i++) begin
        if (z_r[i] < 0) begin
          z_r[i+1] <= z_r[i] + atan_step(i);
        end else begin
          z_r[i+1] <= z_r[i] - atan_step(i);
        end
      end
      // Undo the half-turn fold, zero stays zero
      corr_i <= flip_r[ITERATIONS] ? -x_corr : x_corr;
      corr_q <= flip_r[ITERATIONS] ? -y_corr : y_corr;
    end
  end

endmodule

`default_nettype wire

/* hdl/cordic_vectoring.sv */
// Pipelined vectoring CORDIC, I/Q in, magnitude and phase out
// Half-plane fold, ITERATIONS micro-rotations, gain compensation
`timescale 1ns/1ps
`default_nettype none

module cordic_vectoring #(
  parameter int DATA_WIDTH  = cfr_pkg::DATA_WIDTH_DEF,
  parameter int ITERATIONS  = cfr_pkg::ITERATIONS_DEF,
  parameter int PHASE_WIDTH = cfr_pkg::PHASE_WIDTH_DEF
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic signed [DATA_WIDTH-1:0] data_i,
  input  logic signed [DATA_WIDTH-1:0] data_q,
  output logic        [DATA_WIDTH:0]   mag,
  output logic        [PHASE_WIDTH-1:0] phase
);

  // Fraction bits carried through the iterations
  localparam int GUARD = 4;
  // Sign, two growth bits for sqrt(2)*K, then guard bits
  localparam int XW = DATA_WIDTH + 2 + GUARD;
  localparam int MAG_SHIFT = 15 + GUARD;
  localparam logic signed [XW+16:0] MAG_HALF = (XW + 17)'(1) <<< (MAG_SHIFT - 1);

  logic signed [XW-1:0]          x_r [0:ITERATIONS];
  // Final y residual is never needed, so y stops one stage early
  logic signed [XW-1:0]          y_r [0:ITERATIONS-1];
  logic signed [PHASE_WIDTH-1:0] z_r [0:ITERATIONS];
  logic signed [XW-1:0]          x_in;
  logic signed [XW-1:0]          y_in;
  logic signed [XW+16:0]         mag_prod;

  // Per-stage angle, table value rounded to PHASE_WIDTH bits
  function automatic logic signed [PHASE_WIDTH-1:0] atan_step(input int i);
    logic [31:0] rounded;
    rounded = cfr_pkg::cordic_atan[i] + (32'd1 << (31 - PHASE_WIDTH));
    return rounded[31 -: PHASE_WIDTH];
  endfunction

  // Inputs scaled up by the guard bits
  assign x_in = XW'(data_i) <<< GUARD;
  assign y_in = XW'(data_q) <<< GUARD;

  // x times 1/K, rounded at the guard boundary
  assign mag_prod = x_r[ITERATIONS] * $signed({1'b0, cfr_pkg::CORDIC_GAIN_COMP})
                    + MAG_HALF;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i <= ITERATIONS; i++) begin
        x_r[i] <= '0;
        z_r[i] <= '0;
      end
      for (int i = 0; i < ITERATIONS; i++) begin
        y_r[i] <= '0;
      end
      mag   <= '0;
      phase <= '0;
    end else begin
      //****************************************************************
      // Stage 0: fold left half-plane by 180 degrees
      //****************************************************************
      if (x_in < 0) begin
        x_r[0] <= -x_in;
        y_r[0] <= -y_in;
        z_r[0] <= {1'b1, {(PHASE_WIDTH - 1){1'b0}}};
      end else begin
        x_r[0] <= x_in;
        y_r[0] <= y_in;
        z_r[0] <= '0;
      end
      //****************************************************************
      // Micro-rotations, drive y to zero and sum the angle
      //****************************************************************
      for (int i = 0; i < ITERATIONS; i++) begin
        // Positive y means rotate clockwise
        if (y_r[i] < 0) begin
          x_r[i+1] <= x_r[i] - (y_r[i] >>> i);
          z_r[i+1] <= z_r[i] - atan_step(i);
        end else begin
          x_r[i+1] <= x_r[i] + (y_r[i] >>> i);
          z_r[i+1] <= z_r[i] + atan_step(i);
        end
      end
      for (int i = 0; i < ITERATIONS - 1; i++) begin
        if (y_r[i] < 0) begin
          y_r[i+1] <= y_r[i] + (x_r[i] >>> i);
        end else begin
          y_r[i+1] <= y_r[i] - (x_r[i] >>> i);
        end
      end
      // Gain stage, x is never negative here
      mag   <= mag_prod[MAG_SHIFT +: DATA_WIDTH + 1];
      phase <= z_r[ITERATIONS];
    end
  end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build the CFR clipper simulation with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module cfr_clip_tb \
  -f cfr_clip_top.f -o cfr_clip_sim
status=0
./obj_dir/cfr_clip_sim > sim.log 2>&1 || status=$?
cat sim.log
if [ "$status" -ne 0 ] || grep -q "ERRORS FOUND" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"
